//--- softmax_defs.svh
`ifndef SOFTMAX_DEFS_SVH
`define SOFTMAX_DEFS_SVH

// signed fixed point, one lane
`define LANE_WIDTH 16

// lanes per memory word
`define NUM_LANES 4

// memory and buffer index
`define ADDR_WIDTH 9

`endif

//--- data_pkg.sv
`include "softmax_defs.svh"

package data_pkg;

  typedef logic signed [`LANE_WIDTH-1:0] lane_t;

  // lane 0 sits in the low bits
  typedef lane_t [`NUM_LANES-1:0] vec_t;

  // most negative lane, also the saturation floor
  localparam lane_t lane_min = {1'b1, {(`LANE_WIDTH-1){1'b0}}};

  typedef struct packed {
    logic valid;
    logic last;
    vec_t diff;
  } result_t;

endpackage

//--- ctrl_pkg.sv
`include "softmax_defs.svh"

package ctrl_pkg;

  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  typedef enum logic [1:0] {
    idle,
    load,
    scan,
    drain
  } seq_state_e;

  typedef struct packed {
    logic           en;
    addr_t          addr;
    data_pkg::vec_t data;
  } buf_wr_t;

  typedef struct packed {
    logic  en;
    logic  last;
    addr_t addr;
  } buf_rd_t;

endpackage

//--- pass_sequencer.sv
module pass_sequencer (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  ctrl_pkg::addr_t   start_addr,
  input  ctrl_pkg::addr_t   end_addr,
  output ctrl_pkg::addr_t   mem_addr,
  input  data_pkg::vec_t    mem_data,
  output ctrl_pkg::buf_wr_t buf_wr,
  output ctrl_pkg::buf_rd_t buf_rd,
  output logic              load_valid,
  output data_pkg::vec_t    load_vec,
  output logic              clear,
  output logic              done
);
  import data_pkg::*;
  import ctrl_pkg::*;

  seq_state_e state;
  addr_t      load_addr;
  addr_t      scan_addr;
  addr_t      first_addr;
  addr_t      last_addr;
  logic       drain_cnt;
  logic [1:0] done_pipe;

  logic       wr_en_q;
  addr_t      wr_addr_q;
  vec_t       wr_data_q;
  logic       rd_en_q;
  logic       rd_last_q;
  addr_t      rd_addr_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      load_addr <= '0;
      scan_addr <= '0;
      drain_cnt <= 1'b0;
      clear     <= 1'b0;
      wr_en_q   <= 1'b0;
      rd_en_q   <= 1'b0;
      rd_last_q <= 1'b0;
      done_pipe <= '0;
    end else begin
      clear     <= 1'b0;
      wr_en_q   <= 1'b0;
      rd_en_q   <= 1'b0;
      rd_last_q <= 1'b0;
      // last read flag, two cycles through buffer and subtract
      done_pipe <= {done_pipe[0], rd_en_q & rd_last_q};
      case (state)
        idle: begin
          if (start) begin
            state     <= load;
            load_addr <= start_addr;
            clear     <= 1'b1;
          end
        end
        load: begin
          wr_en_q   <= 1'b1;
          load_addr <= load_addr + 1'b1;
          if (load_addr == last_addr) begin
            state     <= drain;
            drain_cnt <= 1'b0;
          end
        end
        drain: begin
          // let the max tree settle
          drain_cnt <= drain_cnt + 1'b1;
          scan_addr <= first_addr;
          if (drain_cnt) begin
            state <= scan;
          end
        end
        scan: begin
          rd_en_q   <= 1'b1;
          rd_last_q <= (scan_addr == last_addr);
          scan_addr <= scan_addr + 1'b1;
          if (scan_addr == last_addr) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle && start) begin
      first_addr <= start_addr;
      last_addr  <= end_addr - 1'b1;
    end
    if (state == load) begin
      wr_addr_q <= load_addr;
      wr_data_q <= mem_data;
    end
    if (state == scan) begin
      rd_addr_q <= scan_addr;
    end
  end

  assign mem_addr   = load_addr;
  assign buf_wr     = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};
  assign buf_rd     = '{en: rd_en_q, last: rd_last_q, addr: rd_addr_q};
  // tree sees the same word as the buffer write
  assign load_valid = wr_en_q;
  assign load_vec   = wr_data_q;
  assign done       = done_pipe[1];

  a_start_range: assert property (@(posedge clk) disable iff (reset)
    (start && state == idle) |-> (end_addr > start_addr));

  a_no_rw_overlap: assert property (@(posedge clk) disable iff (reset)
    !(buf_wr.en && buf_rd.en));

endmodule

//--- vector_buffer.sv
`include "softmax_defs.svh"

module vector_buffer (
  input  logic              clk,
  input  logic              reset,
  input  ctrl_pkg::buf_wr_t buf_wr,
  input  ctrl_pkg::buf_rd_t buf_rd,
  output logic              rd_valid,
  output logic              rd_last,
  output data_pkg::vec_t    rd_vec
);
  import data_pkg::*;

  localparam int depth = 1 << `ADDR_WIDTH;

  vec_t mem [depth];

  always_ff @(posedge clk) begin
    if (buf_wr.en) begin
      mem[buf_wr.addr] <= buf_wr.data;
    end
    if (buf_rd.en) begin
      rd_vec <= mem[buf_rd.addr];
    end
  end

  // flags follow the read data
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
      rd_last  <= 1'b0;
    end else begin
      rd_valid <= buf_rd.en;
      rd_last  <= buf_rd.en & buf_rd.last;
    end
  end

endmodule

//--- max_tree.sv
module max_tree (
  input  logic            clk,
  input  logic            reset,
  input  logic            clear,
  input  logic            load_valid,
  input  data_pkg::vec_t  load_vec,
  output data_pkg::lane_t max_val
);
  import data_pkg::*;

  lane_t lvl1_lo;
  lane_t lvl1_hi;
  lane_t lvl2;
  logic  stage_valid;
  lane_t stage_max;
  lane_t run_max;

  function automatic lane_t lane_max(lane_t a, lane_t b);
    return (a > b) ? a : b;
  endfunction

  // two-level compare over the four lanes
  assign lvl1_lo = lane_max(load_vec[0], load_vec[1]);
  assign lvl1_hi = lane_max(load_vec[2], load_vec[3]);
  assign lvl2    = lane_max(lvl1_lo, lvl1_hi);

  always_ff @(posedge clk) begin
    if (reset) begin
      stage_valid <= 1'b0;
    end else begin
      stage_valid <= load_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load_valid) begin
      stage_max <= lvl2;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      run_max <= lane_min;
    end else if (clear) begin
      run_max <= lane_min;
    end else if (stage_valid && stage_max > run_max) begin
      run_max <= stage_max;
    end
  end

  assign max_val = run_max;

  // running max only grows within one run
  a_max_monotonic: assert property (@(posedge clk) disable iff (reset)
    !$past(clear) |-> (max_val >= $past(max_val)));

endmodule

//--- shift_sub.sv
`include "softmax_defs.svh"

module shift_sub (
  input  logic              clk,
  input  logic              reset,
  input  logic              rd_valid,
  input  logic              rd_last,
  input  data_pkg::vec_t    rd_vec,
  input  data_pkg::lane_t   max_val,
  output data_pkg::result_t result
);
  import data_pkg::*;

  logic valid_q;
  logic last_q;
  vec_t diff_d;
  vec_t diff_q;

  for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
    logic signed [`LANE_WIDTH:0] wide;

    // one extra bit so the borrow is visible
    assign wide      = rd_vec[i] - max_val;
    assign diff_d[i] = (wide < lane_min) ? lane_min : wide[`LANE_WIDTH-1:0];

    // max is final before scan, so nothing exceeds it
    a_diff_nonpos: assert property (@(posedge clk) disable iff (reset)
      result.valid |-> (result.diff[i] <= 0));
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= rd_valid;
      last_q  <= rd_valid & rd_last;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid) begin
      diff_q <= diff_d;
    end
  end

  assign result = '{valid: valid_q, last: last_q, diff: diff_q};

endmodule

//--- softmax_top.sv
module softmax_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  ctrl_pkg::addr_t   start_addr,
  input  ctrl_pkg::addr_t   end_addr,
  output ctrl_pkg::addr_t   mem_addr,
  input  data_pkg::vec_t    mem_data,
  output data_pkg::result_t result,
  output logic              done
);
  import data_pkg::*;
  import ctrl_pkg::*;

  buf_wr_t buf_wr;
  buf_rd_t buf_rd;
  logic    load_valid;
  vec_t    load_vec;
  logic    clear;
  logic    rd_valid;
  logic    rd_last;
  vec_t    rd_vec;
  lane_t   max_val;

  pass_sequencer u_seq (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .start_addr (start_addr),
    .end_addr   (end_addr),
    .mem_addr   (mem_addr),
    .mem_data   (mem_data),
    .buf_wr     (buf_wr),
    .buf_rd     (buf_rd),
    .load_valid (load_valid),
    .load_vec   (load_vec),
    .clear      (clear),
    .done       (done)
  );

  vector_buffer u_buf (
    .clk      (clk),
    .reset    (reset),
    .buf_wr   (buf_wr),
    .buf_rd   (buf_rd),
    .rd_valid (rd_valid),
    .rd_last  (rd_last),
    .rd_vec   (rd_vec)
  );

  max_tree u_max (
    .clk        (clk),
    .reset      (reset),
    .clear      (clear),
    .load_valid (load_valid),
    .load_vec   (load_vec),
    .max_val    (max_val)
  );

  shift_sub u_sub (
    .clk      (clk),
    .reset    (reset),
    .rd_valid (rd_valid),
    .rd_last  (rd_last),
    .rd_vec   (rd_vec),
    .max_val  (max_val),
    .result   (result)
  );

endmodule

//--- tb_clock.sv
module tb_clock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset held for four rising edges, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

//--- tb_softmax.sv
`include "softmax_defs.svh"

module tb_softmax;
  import data_pkg::*;
  import ctrl_pkg::*;

  localparam int depth      = 1 << `ADDR_WIDTH;
  localparam int lane_floor = -(1 << (`LANE_WIDTH - 1));
  localparam int lane_top   = (1 << (`LANE_WIDTH - 1)) - 1;

  logic    clk;
  logic    reset;
  logic    start;
  addr_t   start_addr;
  addr_t   end_addr;
  addr_t   mem_addr;
  vec_t    mem_data;
  result_t result;
  logic    done;

  vec_t   mem [depth];
  integer seed;
  int     cycle_cnt   = 0;
  int     cycle_limit = 50;

  tb_clock clock_gen (.clk(clk), .reset(reset));

  softmax_top DUT (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .start_addr (start_addr),
    .end_addr   (end_addr),
    .mem_addr   (mem_addr),
    .mem_data   (mem_data),
    .result     (result),
    .done       (done)
  );

  // memory answers in the same cycle
  assign mem_data = mem[mem_addr];

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_vec(input string name, input vec_t exp_v, input vec_t act_v);
    if (act_v !== exp_v) begin
      $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, exp_v, act_v);
      abort_run("vector value mismatch");
    end
  endtask

  task automatic check_lane(input string name, input lane_t exp_l, input lane_t act_l);
    if (act_l !== exp_l) begin
      $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, exp_l, act_l);
      abort_run("lane value mismatch");
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp_a, input addr_t act_a);
    if (act_a !== exp_a) begin
      $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, exp_a, act_a);
      abort_run("address value mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp_f, input logic act_f);
    if (act_f !== exp_f) begin
      $display("FAILED time=%0t %s expected=%b actual=%b", $time, name, exp_f, act_f);
      abort_run("flag value mismatch");
    end
  endtask

  function automatic lane_t model_max(input int first, input int n);
    lane_t peak;
    int    w;
    int    k;
    peak = lane_t'(lane_floor);
    for (w = 0; w < n; w++) begin
      for (k = 0; k < `NUM_LANES; k++) begin
        if (mem[first + w][k] > peak) begin
          peak = mem[first + w][k];
        end
      end
    end
    return peak;
  endfunction

  function automatic lane_t sat_sub(input lane_t x, input lane_t peak);
    int d;
    d = int'(x) - int'(peak);
    if (d < lane_floor) begin
      return lane_t'(lane_floor);
    end
    return lane_t'(d);
  endfunction

  // mix of full-scale positive and most negative lanes
  task automatic write_extremes(input int base, input int count);
    int w;
    int k;
    for (w = 0; w < count; w++) begin
      for (k = 0; k < `NUM_LANES; k++) begin
        if ((w + k) % 3 == 0) begin
          mem[base + w][k] = lane_t'(lane_top);
        end else if ((w + k) % 3 == 1) begin
          mem[base + w][k] = lane_t'(lane_floor);
        end
      end
    end
  endtask

  task automatic run_range(input int first, input int n, input bit inject);
    vec_t  expected [$];
    vec_t  exp_vec;
    lane_t peak;
    int    w;
    int    k;
    int    elapsed;
    int    got;
    logic  exp_valid;
    logic  exp_last;
    // load and scan each take n cycles
    cycle_limit += 2 * n + 10;
    peak = model_max(first, n);
    for (w = 0; w < n; w++) begin
      for (k = 0; k < `NUM_LANES; k++) begin
        exp_vec[k] = sat_sub(mem[first + w][k], peak);
      end
      expected.push_back(exp_vec);
    end
    @(negedge clk);
    start      = 1'b1;
    start_addr = addr_t'(first);
    end_addr   = addr_t'(first + n);
    @(negedge clk);
    start   = 1'b0;
    elapsed = 0;
    got     = 0;
    while (elapsed < 2 * n + 6) begin
      exp_valid = (elapsed >= n + 5) && (elapsed < 2 * n + 5);
      exp_last  = exp_valid && (got == n - 1);
      // one word fetched per load cycle
      if (elapsed < n) begin
        check_addr("mem_addr", addr_t'(first + elapsed), mem_addr);
      end
      check_flag("result.valid", exp_valid, result.valid);
      check_flag("result.last", exp_last, result.last);
      check_flag("done", exp_last, done);
      if (exp_valid) begin
        for (k = 0; k < `NUM_LANES; k++) begin
          if (mem[first + got][k] == lane_t'(lane_floor) && peak > 0) begin
            check_lane("result.diff lane", lane_t'(lane_floor), result.diff[k]);
          end
        end
        check_vec("result.diff", expected[got], result.diff);
        got++;
      end
      // a second start mid-run must be ignored
      if (inject && elapsed == 2) begin
        start      = 1'b1;
        start_addr = '0;
        end_addr   = addr_t'(1);
      end else begin
        start = 1'b0;
      end
      @(negedge clk);
      elapsed++;
    end
    if (got != n) begin
      abort_run("wrong number of results for the run");
    end
  endtask

  task automatic random_run(input bit inject);
    int n;
    int first;
    n     = 1 + int'($unsigned($random(seed)) % 20);
    first = int'($unsigned($random(seed)) % (depth - n));
    run_range(first, n, inject);
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      abort_run("timeout, the DUT did not finish within the cycle limit");
    end
  end

  initial begin
    start      = 1'b0;
    start_addr = '0;
    end_addr   = '0;
    seed       = 67;
    for (int i = 0; i < depth; i++) begin
      mem[i] = {$random(seed), $random(seed)};
    end
    @(negedge clk);
    while (reset) begin
      @(negedge clk);
    end
    repeat (3) begin
      check_flag("result.valid", 1'b0, result.valid);
      check_flag("done", 1'b0, done);
      @(negedge clk);
    end
    random_run(1'b0);
    write_extremes(100, 6);
    run_range(100, 6, 1'b0);
    repeat (10) begin
      random_run(1'b0);
    end
    random_run(1'b1);
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- tb.f
+incdir+.
data_pkg.sv
ctrl_pkg.sv
pass_sequencer.sv
vector_buffer.sv
max_tree.sv
shift_sub.sv
softmax_top.sv
tb_clock.sv
tb_softmax.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_softmax
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
